//--- bench/snowbro2_assertions.sv
// bus protocol assertions
`timescale 1ns/100ps
`default_nettype none

module snowbro2_assertions #(
    parameter bit BUS_SIDE = 1'b1   // bus cycle checks, else gp9001 strobe checks
) (
    input wire       CLK96,
    input wire       RESET96,
    input wire       as_n,
    input wire       dtack_n,
    input wire       prg_cs,
    input wire [5:0] strobes
);

    generate
        if (BUS_SIDE) begin : g_bus
            // dtack trails as_n by the one edge it takes to see as_n high
            dtack_within_as: assert property (@(posedge CLK96) disable iff (RESET96)
                !dtack_n |-> !$past(as_n))
                else $error("dtack_n low outside a bus cycle");

            rom_cs_released: assert property (@(posedge CLK96) disable iff (RESET96)
                $fell(dtack_n) |-> !prg_cs)
                else $error("prg_cs still high after dtack_n fell");
        end else begin : g_gp
            one_strobe: assert property (@(posedge CLK96) disable iff (RESET96)
                $onehot0(strobes))
                else $error("more than one gp9001 strobe high");
        end
    endgenerate

endmodule

// each instance watches its own block, inputs it cannot see are tied off
bind bus_cycle_ctrl snowbro2_assertions #(.BUS_SIDE(1'b1)) u_bus_chk (
    .CLK96   (CLK96),
    .RESET96 (RESET96),
    .as_n    (as_n),
    .dtack_n (dtack_n),
    .prg_cs  (prg_cs),
    .strobes (6'b000000)
);

bind gp9001_cmd snowbro2_assertions #(.BUS_SIDE(1'b0)) u_gp_chk (
    .CLK96   (CLK96),
    .RESET96 (RESET96),
    .as_n    (1'b0),
    .dtack_n (1'b1),
    .prg_cs  (1'b0),
    .strobes (strobe)
);

`default_nettype wire

//--- bench/tb_snowbro2.sv
// snowbro2 main bus testbench
`timescale 1ns/100ps
`default_nettype none

module tb_snowbro2 import snowbro2_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;   // longest test takes about 200 cycles

    logic                 CLK96;
    logic                 RESET96;
    logic [23:1]          addr;
    logic                 as_n, uds_n, lds_n, rw;
    logic [15:0]          cpu_dout;
    logic                 prg_ok;
    logic [15:0]          prg_data;
    logic                 gp9001_ack;
    logic [15:0]          gp9001_dout;
    logic [6:0]           joystick1, joystick2, joystick3, joystick4;
    logic [1:0]           start_button, coin_input;
    logic                 service, dip_test;
    logic [7:0]           dipsw_a, dipsw_b, dipsw_c;
    logic [PALRAM_AW-1:0] palram_addr;

    wire [15:0]           cpu_din;
    wire                  dtack_n;
    wire                  prg_cs;
    wire [PRG_AW-1:0]     prg_addr;
    wire                  gp_select_reg, gp_write_reg, gp_write_ram;
    wire                  gp_read_ram_h, gp_read_ram_l, gp_set_ram_ptr;
    wire [15:0]           palram_data;
    wire [5:0]            strobes;

    int          err_count;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;

    assign strobes = {gp_select_reg, gp_write_reg, gp_write_ram,
                      gp_read_ram_h, gp_read_ram_l, gp_set_ram_ptr};

    snowbro2_main_bus uut (.*);

    initial begin
        CLK96 = 1'b0;
        forever #20 CLK96 = ~CLK96;
    end

    always @(posedge CLK96) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR %s: got %h, expected %h at %0t", sig, got, exp, $time);
        err_count = err_count + 1;
    endtask

    task automatic report_failure(input string msg);
        $display("%s at %0t", msg, $time);
        err_count = err_count + 1;
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (err_count != errs_before) begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // lat counts edges from the one that first sees as_n low
    task automatic bus_cycle(input logic [23:0] byte_addr, input logic rd,
                             input logic [1:0] lanes, input logic [15:0] wdata,
                             output logic [15:0] rdata, output int lat);
        @(posedge CLK96);
        addr     <= byte_addr[23:1];
        rw       <= rd;
        uds_n    <= ~lanes[1];
        lds_n    <= ~lanes[0];
        cpu_dout <= wdata;
        @(posedge CLK96);
        as_n <= 1'b0;
        @(posedge CLK96);
        lat = 0;
        @(negedge CLK96);
        while (dtack_n) begin
            @(negedge CLK96);
            lat = lat + 1;
        end
        rdata = cpu_din;
        @(posedge CLK96);
        as_n <= 1'b1;
        @(negedge CLK96);
        while (!dtack_n)
            @(negedge CLK96);   // cpu side sees the cycle closed
    endtask

    task automatic bus_read(input logic [23:0] byte_addr, output logic [15:0] rdata,
                            output int lat);
        bus_cycle(byte_addr, 1'b1, 2'b11, 16'h0000, rdata, lat);
    endtask

    task automatic bus_write(input logic [23:0] byte_addr, input logic [1:0] lanes,
                             input logic [15:0] wdata);
        logic [15:0] discard_q;
        int          discard_lat;
        bus_cycle(byte_addr, 1'b0, lanes, wdata, discard_q, discard_lat);
    endtask

    // player byte, active low, directions in the low nibble
    function automatic logic [7:0] pad_byte(input logic [6:0] j, input logic third);
        logic [7:0] b;
        b    = 8'h00;
        b[0] = ~j[3];
        b[1] = ~j[2];
        b[2] = ~j[1];
        b[3] = ~j[0];
        b[4] = ~j[4];
        b[5] = ~j[5];
        b[6] = third & ~j[6];
        return b;
    endfunction

    function automatic logic [15:0] io_expect(input logic [11:0] off);
        logic [7:0] sys;
        sys    = 8'h00;
        sys[0] = ~service;
        sys[2] = ~dip_test;
        sys[3] = ~coin_input[0];
        sys[4] = ~coin_input[1];
        sys[5] = ~start_button[0];
        sys[6] = ~start_button[1];
        case (off)
            12'h000: return {dipsw_c, dipsw_c};
            12'h004: return {dipsw_a, dipsw_a};
            12'h008: return {dipsw_b, dipsw_b};
            12'h00C: return {2{pad_byte(joystick1, 1'b0)}};
            12'h010: return {2{pad_byte(joystick2, 1'b0)}};
            12'h014: return {2{pad_byte(joystick3, 1'b1)}};
            12'h018: return {2{pad_byte(joystick4, 1'b1)}};
            12'h01C: return {dipsw_c, sys};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic test_reset();
        int errs;
        errs = err_count;
        if (dtack_n !== 1'b1)
            report_mismatch("dtack_n", 32'(dtack_n), 32'h1);
        if (prg_cs !== 1'b0)
            report_mismatch("prg_cs", 32'(prg_cs), 32'h0);
        if (strobes !== 6'h00)
            report_mismatch("gp strobes", 32'(strobes), 32'h0);
        if (cpu_din !== 16'h0000)
            report_mismatch("cpu_din", 32'(cpu_din), 32'h0);
        close_test("reset", errs);
    endtask

    task automatic test_work_ram();
        logic [23:0] wa [8];
        logic [15:0] model [8];
        logic [15:0] d;
        logic [15:0] q;
        int          lat;
        int          errs;
        errs = err_count;
        for (int i = 0; i < 8; i++) begin
            wa[i]    = {8'h10, 12'($urandom), i[2:0], 1'b0};   // low bits keep them apart
            model[i] = 16'($urandom);
            bus_write(wa[i], 2'b11, model[i]);
        end
        for (int i = 0; i < 8; i++) begin
            d = 16'($urandom);
            if (i[0]) begin
                bus_write(wa[i], 2'b01, d);
                model[i][7:0] = d[7:0];
            end else begin
                bus_write(wa[i], 2'b10, d);
                model[i][15:8] = d[15:8];
            end
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(wa[i], q, lat);
            if (q !== model[i])
                report_mismatch("cpu_din", 32'(q), 32'(model[i]));
            if (lat != 3)
                report_mismatch("dtack latency", 32'(lat), 32'h3);
        end
        close_test("work ram", errs);
    endtask

    task automatic test_palette_ram();
        logic [PALRAM_AW-1:0] n;
        logic [15:0]          d;
        logic [15:0]          q;
        int                   lat;
        int                   errs;
        errs = err_count;
        for (int i = 0; i < 4; i++) begin
            n = {9'($urandom), i[1:0]};
            d = 16'($urandom);
            bus_write(24'h400000 + {12'h000, n, 1'b0}, 2'b11, d);
            bus_read(24'h400000 + {12'h000, n, 1'b0}, q, lat);
            if (q !== d)
                report_mismatch("cpu_din", 32'(q), 32'(d));
            @(posedge CLK96);
            palram_addr <= n;
            @(posedge CLK96);
            @(negedge CLK96);   // one cycle of video port latency
            if (palram_data !== d)
                report_mismatch("palram_data", 32'(palram_data), 32'(d));
        end
        close_test("palette ram", errs);
    endtask

    task automatic test_input_ports();
        logic [11:0] off;
        logic [15:0] q;
        int          lat;
        int          errs;
        errs = err_count;
        @(posedge CLK96);
        joystick1    <= 7'($urandom);
        joystick2    <= 7'($urandom);
        joystick3    <= 7'($urandom);
        joystick4    <= 7'($urandom);
        start_button <= 2'($urandom);
        coin_input   <= 2'($urandom);
        service      <= 1'($urandom);
        dip_test     <= 1'($urandom);
        dipsw_a      <= 8'($urandom);
        dipsw_b      <= 8'($urandom);
        dipsw_c      <= 8'($urandom);
        for (int i = 0; i < 9; i++) begin
            off = 12'(i * 4);   // 0x020 is past the last register
            bus_read({12'h700, off}, q, lat);
            if (q !== io_expect(off))
                report_mismatch("cpu_din", 32'(q), 32'(io_expect(off)));
            if (lat != 2)
                report_mismatch("dtack latency", 32'(lat), 32'h2);
        end
        bus_read(24'h200000, q, lat);
        if (q !== 16'h0000)
            report_mismatch("cpu_din", 32'(q), 32'h0);
        if (lat != 2)
            report_mismatch("dtack latency", 32'(lat), 32'h2);
        close_test("input ports", errs);
    endtask

    // rom side, keeps prg_ok low for a while
    task automatic serve_rom(input logic [PRG_AW-1:0] exp_addr, input int delay,
                             input logic [15:0] d);
        @(negedge CLK96);
        while (!prg_cs)
            @(negedge CLK96);
        if (prg_addr !== exp_addr)
            report_mismatch("prg_addr", 32'(prg_addr), 32'(exp_addr));
        repeat (delay) begin
            @(negedge CLK96);
            if (dtack_n !== 1'b1)
                report_failure("dtack_n fell while prg_ok was still low");
        end
        @(posedge CLK96);
        prg_ok   <= 1'b1;
        prg_data <= d;
        while (dtack_n)
            @(negedge CLK96);
        if (prg_cs !== 1'b0)
            report_mismatch("prg_cs", 32'(prg_cs), 32'h0);
        @(posedge CLK96);
        prg_ok <= 1'b0;
    endtask

    task automatic test_rom();
        logic [23:0] a;
        logic [15:0] d;
        logic [15:0] q;
        int          delay;
        int          lat;
        int          errs;
        errs = err_count;
        for (int i = 0; i < 4; i++) begin
            a     = {5'h00, 18'($urandom), 1'b0};   // always below 0x080000
            d     = 16'($urandom);
            delay = $urandom_range(8, 1);
            fork
                bus_read(a, q, lat);
                serve_rom(a[18:1], delay, d);
            join
            if (q !== d)
                report_mismatch("cpu_din", 32'(q), 32'(d));
        end
        close_test("program rom", errs);
    endtask

    // video controller side, holds back the ack
    task automatic serve_gp(input logic [5:0] exp_strobe, input int delay,
                            input logic [15:0] d);
        @(negedge CLK96);
        if (exp_strobe == 6'h00) begin
            while (dtack_n) begin
                if (strobes !== 6'h00)
                    report_mismatch("gp strobes", 32'(strobes), 32'h0);
                @(negedge CLK96);
            end
        end else begin
            while (strobes === 6'h00)
                @(negedge CLK96);
            if (strobes !== exp_strobe)
                report_mismatch("gp strobes", 32'(strobes), 32'(exp_strobe));
            repeat (delay) begin
                @(negedge CLK96);
                if (strobes !== exp_strobe || dtack_n !== 1'b1)
                    report_failure("strobe dropped or dtack_n fell before gp9001_ack");
            end
            @(posedge CLK96);
            gp9001_ack  <= 1'b1;
            gp9001_dout <= d;
            while (dtack_n)
                @(negedge CLK96);
            @(posedge CLK96);
            gp9001_ack <= 1'b0;
        end
    endtask

    task automatic test_gp9001();
        logic [3:0]  off_tab [9];
        logic        rd_tab [9];
        logic [5:0]  stb_tab [9];
        logic [23:0] a;
        logic [15:0] d;
        logic [15:0] w;
        logic [15:0] q;
        int          delay;
        int          lat;
        int          errs;
        errs    = err_count;
        off_tab = '{GP_RAM_H, GP_RAM_L, GP_PTR, GP_RAM_H, GP_RAM_L,
                    GP_SEL_REG, GP_WR_REG, GP_SEL_REG, 4'h2};
        rd_tab  = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
        // {select_reg, write_reg, write_ram, read_ram_h, read_ram_l, set_ram_ptr}
        stb_tab = '{6'b000100, 6'b000010, 6'b000001, 6'b001000, 6'b001000,
                    6'b100000, 6'b010000, 6'b000000, 6'b000000};
        for (int i = 0; i < 9; i++) begin
            a     = 24'h300000 | {20'h00000, off_tab[i]};
            d     = 16'($urandom);
            w     = 16'($urandom);
            delay = $urandom_range(4, 1);
            fork
                bus_cycle(a, rd_tab[i], 2'b11, w, q, lat);
                serve_gp(stb_tab[i], delay, d);
            join
            if (rd_tab[i] && stb_tab[i] != 6'h00 && q !== d)
                report_mismatch("cpu_din", 32'(q), 32'(d));
            if (stb_tab[i] == 6'h00 && lat != 3)
                report_mismatch("dtack latency", 32'(lat), 32'h3);
        end
        close_test("gp9001 commands", errs);
    endtask

    initial begin
        void'($urandom(32'he44b));
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        RESET96      = 1'b1;
        addr         = '0;
        as_n         = 1'b1;
        uds_n        = 1'b1;
        lds_n        = 1'b1;
        rw           = 1'b1;
        cpu_dout     = 16'h0000;
        prg_ok       = 1'b0;
        prg_data     = 16'h0000;
        gp9001_ack   = 1'b0;
        gp9001_dout  = 16'h0000;
        joystick1    = 7'h00;
        joystick2    = 7'h00;
        joystick3    = 7'h00;
        joystick4    = 7'h00;
        start_button = 2'b00;
        coin_input   = 2'b00;
        service      = 1'b0;
        dip_test     = 1'b0;
        dipsw_a      = 8'h00;
        dipsw_b      = 8'h00;
        dipsw_c      = 8'h00;
        palram_addr  = '0;
        repeat (16) @(posedge CLK96);
        RESET96 <= 1'b0;
        @(negedge CLK96);
        test_reset();
        test_work_ram();
        test_palette_ram();
        test_input_ports();
        test_rom();
        test_gp9001();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- common/snowbro2_pkg.sv
// snowbro2 main bus definitions
`default_nettype none

package snowbro2_pkg;

    // cpu byte address, seen flat or split into map fields
    typedef union packed {
        logic [23:0] flat;
        struct packed {
            logic [3:0]  region;
            logic [7:0]  page;
            logic [11:0] offset;
        } fields;
    } bus_addr_u;

    localparam logic [23:0] ROM_LIMIT     = 24'h080000; // first byte above program rom

    localparam logic [3:0]  REGION_WRAM   = 4'd1;
    localparam logic [3:0]  REGION_GP9001 = 4'd3;
    localparam logic [3:0]  REGION_PALRAM = 4'd4;
    localparam logic [3:0]  REGION_IO     = 4'd7;

    localparam logic [3:0]  WRAM_PAGE_HI  = 4'h0;  // 0x100000 - 0x10ffff
    localparam logic [7:0]  IO_PAGE       = 8'h00;

    localparam int WRAM_AW   = 15;
    localparam int PALRAM_AW = 11;
    localparam int PRG_AW    = 18;

    // i/o register offsets
    localparam logic [11:0] IO_JUMPER = 12'h000;
    localparam logic [11:0] IO_DSWA   = 12'h004;
    localparam logic [11:0] IO_DSWB   = 12'h008;
    localparam logic [11:0] IO_IN1    = 12'h00C;
    localparam logic [11:0] IO_IN2    = 12'h010;
    localparam logic [11:0] IO_IN3    = 12'h014;
    localparam logic [11:0] IO_IN4    = 12'h018;
    localparam logic [11:0] IO_SYS    = 12'h01C;

    // gp9001 offsets, low nibble only
    localparam logic [3:0] GP_PTR     = 4'h0;
    localparam logic [3:0] GP_RAM_H   = 4'h4;
    localparam logic [3:0] GP_RAM_L   = 4'h6;
    localparam logic [3:0] GP_SEL_REG = 4'h8;
    localparam logic [3:0] GP_WR_REG  = 4'hC;

    // bus cycle states
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_DECODE = 2'd1;
    localparam logic [1:0] ST_WAIT   = 2'd2;
    localparam logic [1:0] ST_ACK    = 2'd3;

    // registered region select
    localparam logic [2:0] SEL_NONE = 3'd0;
    localparam logic [2:0] SEL_ROM  = 3'd1;
    localparam logic [2:0] SEL_WRAM = 3'd2;
    localparam logic [2:0] SEL_GP   = 3'd3;
    localparam logic [2:0] SEL_PAL  = 3'd4;
    localparam logic [2:0] SEL_IO   = 3'd5;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the snowbro2 main bus testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_snowbro2 -f src.f -o sim_snowbro2
./obj_dir/sim_snowbro2 | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- src.f
common/snowbro2_pkg.sv
src/memory/work_ram.sv
src/memory/palette_ram.sv
src/input_ports.sv
src/gp9001_cmd.sv
src/bus_cycle_ctrl.sv
src/snowbro2_main_bus.sv
bench/snowbro2_assertions.sv
bench/tb_snowbro2.sv

//--- src/bus_cycle_ctrl.sv
// 68000 bus cycle controller
`timescale 1ns/100ps
`default_nettype none

module bus_cycle_ctrl import snowbro2_pkg::*; (
    input  wire               CLK96,
    input  wire               RESET96,
    input  wire bus_addr_u    bus_addr,
    input  wire               as_n,
    input  wire               uds_n,
    input  wire               lds_n,
    input  wire               rw,
    input  wire               prg_ok,
    input  wire [15:0]        prg_data,
    input  wire [15:0]        wram_q,
    input  wire [15:0]        pal_q,
    input  wire [15:0]        io_rdata,
    input  wire               gp_done,
    input  wire [15:0]        gp_rdata,
    output logic [15:0]       cpu_din,
    output logic              dtack_n,
    output logic              prg_cs,
    output logic [PRG_AW-1:0] prg_addr,
    output logic [1:0]        wram_we,
    output logic [1:0]        pal_we,
    output logic              gp_start
);

    logic [1:0]  state;
    logic [2:0]  sel;        // region of the running cycle
    logic [2:0]  sel_next;
    logic        ram_rdy;    // ram read data has settled
    logic        done;
    logic [15:0] rd_mux;
    logic [1:0]  lanes;

    assign lanes = {~uds_n, ~lds_n} & {2{~rw}};   // writes only

    // rom wins over everything, then the mapped regions
    always_comb begin
        if (bus_addr.flat < ROM_LIMIT)
            sel_next = SEL_ROM;
        else if (bus_addr.fields.region == REGION_WRAM &&
                 bus_addr.fields.page[7:4] == WRAM_PAGE_HI)
            sel_next = SEL_WRAM;
        else if (bus_addr.fields.region == REGION_GP9001)
            sel_next = SEL_GP;
        else if (bus_addr.fields.region == REGION_PALRAM)
            sel_next = SEL_PAL;
        else if (bus_addr.fields.region == REGION_IO && bus_addr.fields.page == IO_PAGE)
            sel_next = SEL_IO;
        else
            sel_next = SEL_NONE;
    end

    always_comb begin
        case (sel)
            SEL_ROM:  rd_mux = prg_data;
            SEL_WRAM: rd_mux = wram_q;
            SEL_PAL:  rd_mux = pal_q;
            SEL_IO:   rd_mux = io_rdata;
            SEL_GP:   rd_mux = gp_rdata;
            default:  rd_mux = 16'h0000;   // unmapped
        endcase
    end

    // end of the wait phase per region
    always_comb begin
        case (sel)
            SEL_ROM:          done = prg_ok;
            SEL_WRAM, SEL_PAL: done = ram_rdy;
            SEL_GP:           done = gp_done;
            default:          done = 1'b1;
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state    <= ST_IDLE;
            sel      <= SEL_NONE;
            ram_rdy  <= 1'b0;
            dtack_n  <= 1'b1;
            prg_cs   <= 1'b0;
            wram_we  <= 2'b00;
            pal_we   <= 2'b00;
            gp_start <= 1'b0;
            cpu_din  <= 16'h0000;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!as_n)
                        state <= ST_DECODE;
                end
                ST_DECODE: begin
                    sel      <= sel_next;
                    ram_rdy  <= 1'b0;
                    prg_cs   <= (sel_next == SEL_ROM);
                    wram_we  <= (sel_next == SEL_WRAM) ? lanes : 2'b00;
                    pal_we   <= (sel_next == SEL_PAL) ? lanes : 2'b00;
                    gp_start <= (sel_next == SEL_GP);   // single pulse
                    state    <= ST_WAIT;
                end
                ST_WAIT: begin
                    wram_we  <= 2'b00;
                    pal_we   <= 2'b00;
                    gp_start <= 1'b0;
                    if (sel == SEL_WRAM || sel == SEL_PAL)
                        ram_rdy <= 1'b1;
                    if (done) begin
                        cpu_din <= rw ? rd_mux : 16'h0000;
                        prg_cs  <= 1'b0;
                        dtack_n <= 1'b0;
                        state   <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // hold dtack until the cpu ends the cycle
                    if (as_n) begin
                        dtack_n <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state == ST_DECODE)
            prg_addr <= bus_addr.flat[PRG_AW:1];   // rom word address
    end

endmodule

`default_nettype wire

//--- src/gp9001_cmd.sv
// gp9001 command strobes
`timescale 1ns/100ps
`default_nettype none

module gp9001_cmd import snowbro2_pkg::*; (
    input  wire         CLK96,
    input  wire         RESET96,
    input  wire         gp_start,
    input  wire [3:0]   offset,
    input  wire         rw,
    input  wire         gp9001_ack,
    input  wire [15:0]  gp9001_dout,
    output logic        gp_select_reg,
    output logic        gp_write_reg,
    output logic        gp_write_ram,
    output logic        gp_read_ram_h,
    output logic        gp_read_ram_l,
    output logic        gp_set_ram_ptr,
    output logic        gp_done,
    output logic [15:0] gp_rdata
);

    logic [5:0] cmd;      // {sel, wr_reg, wr_ram, rd_h, rd_l, ptr}
    logic [5:0] strobe;
    logic       busy;

    // ram_h and ram_l both map to the data port on writes
    assign cmd[5] = !rw && offset == GP_SEL_REG;
    assign cmd[4] = !rw && offset == GP_WR_REG;
    assign cmd[3] = !rw && (offset == GP_RAM_H || offset == GP_RAM_L);
    assign cmd[2] = rw && offset == GP_RAM_H;
    assign cmd[1] = rw && offset == GP_RAM_L;
    assign cmd[0] = !rw && offset == GP_PTR;

    assign busy = |strobe;

    assign {gp_select_reg, gp_write_reg, gp_write_ram,
            gp_read_ram_h, gp_read_ram_l, gp_set_ram_ptr} = strobe;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            strobe  <= 6'b000000;
            gp_done <= 1'b0;
        end else begin
            gp_done <= 1'b0;
            if (gp_start) begin
                strobe  <= cmd;
                gp_done <= ~|cmd;   // nothing to ask the chip
            end else if (busy && gp9001_ack) begin
                strobe  <= 6'b000000;
                gp_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (busy && gp9001_ack)
            gp_rdata <= gp9001_dout;   // valid with the ack
    end

endmodule

`default_nettype wire

//--- src/input_ports.sv
// cabinet input ports
`timescale 1ns/100ps
`default_nettype none

module input_ports import snowbro2_pkg::*; (
    input  wire [11:0]  offset,
    input  wire [6:0]   joystick1,
    input  wire [6:0]   joystick2,
    input  wire [6:0]   joystick3,
    input  wire [6:0]   joystick4,
    input  wire [1:0]   start_button,
    input  wire [1:0]   coin_input,
    input  wire         service,
    input  wire         dip_test,
    input  wire [7:0]   dipsw_a,
    input  wire [7:0]   dipsw_b,
    input  wire [7:0]   dipsw_c,
    output logic [15:0] io_rdata
);

    logic [7:0] p1_byte;
    logic [7:0] p2_byte;
    logic [7:0] p3_byte;
    logic [7:0] p4_byte;
    logic [7:0] sys_byte;

    // inputs come in active high, the board wants them low
    assign p1_byte = {2'b00, ~joystick1[5], ~joystick1[4],
                      ~joystick1[0], ~joystick1[1], ~joystick1[2], ~joystick1[3]};
    assign p2_byte = {2'b00, ~joystick2[5], ~joystick2[4],
                      ~joystick2[0], ~joystick2[1], ~joystick2[2], ~joystick2[3]};
    // players 3 and 4 have a third button
    assign p3_byte = {1'b0, ~joystick3[6], ~joystick3[5], ~joystick3[4],
                      ~joystick3[0], ~joystick3[1], ~joystick3[2], ~joystick3[3]};
    assign p4_byte = {1'b0, ~joystick4[6], ~joystick4[5], ~joystick4[4],
                      ~joystick4[0], ~joystick4[1], ~joystick4[2], ~joystick4[3]};

    assign sys_byte = {1'b0, ~start_button[1], ~start_button[0],
                       ~coin_input[1], ~coin_input[0], ~dip_test, 1'b0, ~service};

    always_comb begin
        case (offset)
            IO_JUMPER: io_rdata = {2{dipsw_c}};
            IO_DSWA:   io_rdata = {2{dipsw_a}};
            IO_DSWB:   io_rdata = {2{dipsw_b}};
            IO_IN1:    io_rdata = {2{p1_byte}};
            IO_IN2:    io_rdata = {2{p2_byte}};
            IO_IN3:    io_rdata = {2{p3_byte}};
            IO_IN4:    io_rdata = {2{p4_byte}};
            IO_SYS:    io_rdata = {dipsw_c, sys_byte};   // region jumpers on top
            default:   io_rdata = 16'h0000;
        endcase
    end

endmodule

`default_nettype wire

//--- src/memory/palette_ram.sv
// palette ram, cpu and video ports
`timescale 1ns/100ps
`default_nettype none

module palette_ram import snowbro2_pkg::*; (
    input  wire                  CLK96,
    input  wire [PALRAM_AW-1:0]  cpu_addr,
    input  wire [15:0]           wdata,
    input  wire [1:0]            we,
    input  wire [PALRAM_AW-1:0]  video_addr,
    output logic [15:0]          cpu_q,
    output logic [15:0]          video_q
);

    logic [15:0] mem [0:(1 << PALRAM_AW) - 1];

    // port a, cpu read and byte writes
    always_ff @(posedge CLK96) begin
        if (we[1])
            mem[cpu_addr][15:8] <= wdata[15:8];
        if (we[0])
            mem[cpu_addr][7:0] <= wdata[7:0];
        cpu_q <= mem[cpu_addr];
    end

    // port b, video side lookups
    always_ff @(posedge CLK96) begin
        video_q <= mem[video_addr];
    end

endmodule

`default_nettype wire

//--- src/memory/work_ram.sv
// main cpu work ram
`timescale 1ns/100ps
`default_nettype none

module work_ram import snowbro2_pkg::*; (
    input  wire                CLK96,
    input  wire [WRAM_AW-1:0]  word_addr,
    input  wire [15:0]         wdata,
    input  wire [1:0]          we,        // {upper, lower}
    output logic [15:0]        q
);

    logic [15:0] mem [0:(1 << WRAM_AW) - 1];

    always_ff @(posedge CLK96) begin
        if (we[1])
            mem[word_addr][15:8] <= wdata[15:8];
        if (we[0])
            mem[word_addr][7:0] <= wdata[7:0];
        q <= mem[word_addr];   // old data on a write
    end

endmodule

`default_nettype wire

//--- src/snowbro2_main_bus.sv
// snowbro2 main bus glue
`timescale 1ns/100ps
`default_nettype none

module snowbro2_main_bus import snowbro2_pkg::*; (
    input  wire                  CLK96,
    input  wire                  RESET96,

    // 68000 side
    input  wire [23:1]           addr,
    input  wire                  as_n,
    input  wire                  uds_n,
    input  wire                  lds_n,
    input  wire                  rw,
    input  wire [15:0]           cpu_dout,
    output logic [15:0]          cpu_din,
    output logic                 dtack_n,

    // program rom
    output logic                 prg_cs,
    output logic [PRG_AW-1:0]    prg_addr,
    input  wire                  prg_ok,
    input  wire [15:0]           prg_data,

    // gp9001 video controller
    output logic                 gp_select_reg,
    output logic                 gp_write_reg,
    output logic                 gp_write_ram,
    output logic                 gp_read_ram_h,
    output logic                 gp_read_ram_l,
    output logic                 gp_set_ram_ptr,
    input  wire                  gp9001_ack,
    input  wire [15:0]           gp9001_dout,

    // cabinet
    input  wire [6:0]            joystick1,
    input  wire [6:0]            joystick2,
    input  wire [6:0]            joystick3,
    input  wire [6:0]            joystick4,
    input  wire [1:0]            start_button,
    input  wire [1:0]            coin_input,
    input  wire                  service,
    input  wire                  dip_test,
    input  wire [7:0]            dipsw_a,
    input  wire [7:0]            dipsw_b,
    input  wire [7:0]            dipsw_c,

    // palette video port
    input  wire [PALRAM_AW-1:0]  palram_addr,
    output logic [15:0]          palram_data
);

    bus_addr_u   bus_addr;
    logic [1:0]  wram_we;
    logic [1:0]  pal_we;
    logic [15:0] wram_q;
    logic [15:0] pal_q;
    logic [15:0] io_rdata;
    logic        gp_start;
    logic        gp_done;
    logic [15:0] gp_rdata;

    assign bus_addr.flat = {addr, 1'b0};   // byte address, easier to match the map

    bus_cycle_ctrl u_ctrl (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .bus_addr (bus_addr),
        .as_n     (as_n),
        .uds_n    (uds_n),
        .lds_n    (lds_n),
        .rw       (rw),
        .prg_ok   (prg_ok),
        .prg_data (prg_data),
        .wram_q   (wram_q),
        .pal_q    (pal_q),
        .io_rdata (io_rdata),
        .gp_done  (gp_done),
        .gp_rdata (gp_rdata),
        .cpu_din  (cpu_din),
        .dtack_n  (dtack_n),
        .prg_cs   (prg_cs),
        .prg_addr (prg_addr),
        .wram_we  (wram_we),
        .pal_we   (pal_we),
        .gp_start (gp_start)
    );

    work_ram u_wram (
        .CLK96     (CLK96),
        .word_addr (bus_addr.flat[WRAM_AW:1]),
        .wdata     (cpu_dout),
        .we        (wram_we),
        .q         (wram_q)
    );

    palette_ram u_palram (
        .CLK96      (CLK96),
        .cpu_addr   (bus_addr.flat[PALRAM_AW:1]),
        .wdata      (cpu_dout),
        .we         (pal_we),
        .video_addr (palram_addr),
        .cpu_q      (pal_q),
        .video_q    (palram_data)
    );

    input_ports u_inputs (
        .offset       (bus_addr.fields.offset),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .joystick3    (joystick3),
        .joystick4    (joystick4),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .io_rdata     (io_rdata)
    );

    gp9001_cmd u_gpcmd (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .gp_start       (gp_start),
        .offset         (bus_addr.fields.offset[3:0]),
        .rw             (rw),
        .gp9001_ack     (gp9001_ack),
        .gp9001_dout    (gp9001_dout),
        .gp_select_reg  (gp_select_reg),
        .gp_write_reg   (gp_write_reg),
        .gp_write_ram   (gp_write_ram),
        .gp_read_ram_h  (gp_read_ram_h),
        .gp_read_ram_l  (gp_read_ram_l),
        .gp_set_ram_ptr (gp_set_ram_ptr),
        .gp_done        (gp_done),
        .gp_rdata       (gp_rdata)
    );

endmodule

`default_nettype wire
